// File: include/sramx_axi_settings.svh
`ifndef SRAMX_AXI_SETTINGS_SVH
`define SRAMX_AXI_SETTINGS_SVH

// ****************************************
// bus widths
// ****************************************

// byte address width.
`define SRAMX_AXI_ADDR_WIDTH 32

// data word width, a multiple of 8.
`define SRAMX_AXI_DATA_WIDTH 32

// ****************************************
// storage
// ****************************************

// 256 words in the array.
`define SRAMX_AXI_DEPTH_LOG2 8

`endif

// File: verilog/sramx_axi_pkg.sv
`include "sramx_axi_settings.svh"

package sramx_axi_pkg;

    // ****************************************
    // vector types
    // ****************************************

    typedef logic [`SRAMX_AXI_ADDR_WIDTH-1:0] addr_t;     // byte address.
    typedef logic [`SRAMX_AXI_DATA_WIDTH-1:0] word_t;     // data word.
    typedef logic [`SRAMX_AXI_DATA_WIDTH/8-1:0] strobe_t; // one bit per byte lane.

    // 0 byte, 1 halfword, 2 word, 3 invalid.
    typedef logic [1:0] sramx_size_t;

    typedef logic [`SRAMX_AXI_DEPTH_LOG2-1:0] word_index_t;

    // ****************************************
    // slave sequencing
    // ****************************************

    typedef enum logic [2:0] {
        idle,
        read_wait,
        read_resp,
        write_data,
        write_resp
    } slave_state_t;

endpackage

// File: verilog/sram_byte_array.sv
`include "sramx_axi_settings.svh"

module sram_byte_array (
    input  logic                       clk,
    input  logic                       rd_en,
    input  sramx_axi_pkg::word_index_t rd_index,
    output sramx_axi_pkg::word_t       rd_data,
    input  logic                       wr_en,
    input  sramx_axi_pkg::word_index_t wr_index,
    input  sramx_axi_pkg::word_t       wr_data,
    input  sramx_axi_pkg::strobe_t     wr_strb
);

    localparam int DEPTH = 1 << `SRAMX_AXI_DEPTH_LOG2;
    localparam int LANES = `SRAMX_AXI_DATA_WIDTH / 8;

    sramx_axi_pkg::word_t mem [DEPTH];

    // byte lane writes.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_index][8*lane +: 8] <= wr_data[8*lane +: 8];
                end
            end
        end
    end

    // registered read, holds until the next rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

// File: verilog/axi_sram_slave.sv
`include "sramx_axi_settings.svh"

module axi_sram_slave (
    input  logic                       clk,
    input  logic                       reset,

    // axi read side.
    input  logic                       ar_valid,
    input  sramx_axi_pkg::addr_t       ar_addr,
    output logic                       ar_ready,
    output logic                       r_valid,
    output sramx_axi_pkg::word_t       r_data,
    input  logic                       r_ready,

    // axi write side.
    input  logic                       aw_valid,
    input  sramx_axi_pkg::addr_t       aw_addr,
    output logic                       aw_ready,
    input  logic                       w_valid,
    input  sramx_axi_pkg::word_t       w_data,
    input  sramx_axi_pkg::strobe_t     w_strb,
    output logic                       w_ready,
    output logic                       b_valid,
    input  logic                       b_ready,

    // array port.
    output logic                       rd_en,
    output sramx_axi_pkg::word_index_t rd_index,
    input  sramx_axi_pkg::word_t       rd_data,
    output logic                       wr_en,
    output sramx_axi_pkg::word_index_t wr_index,
    output sramx_axi_pkg::word_t       wr_data,
    output sramx_axi_pkg::strobe_t     wr_strb
);

    sramx_axi_pkg::slave_state_t state;
    sramx_axi_pkg::slave_state_t state_next;
    sramx_axi_pkg::word_index_t  saved_wr_index;

    logic ar_fire;
    logic aw_fire;
    logic w_fire;

    // ****************************************
    // address phase
    // ****************************************

    // one address phase at a time, reads first.
    assign ar_ready = (state == sramx_axi_pkg::idle);
    assign aw_ready = (state == sramx_axi_pkg::idle) && !ar_valid;

    assign ar_fire = ar_valid && ar_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // upper address bits ignored, so addresses alias.
    assign rd_en    = ar_fire;
    assign rd_index = ar_addr[`SRAMX_AXI_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            saved_wr_index <= aw_addr[`SRAMX_AXI_DEPTH_LOG2+1:2];
        end
    end

    // ****************************************
    // phase sequencing
    // ****************************************

    always_comb begin
        state_next = state;
        case (state)
            sramx_axi_pkg::idle: begin
                if (ar_fire) begin
                    state_next = sramx_axi_pkg::read_wait;
                end else if (aw_fire) begin
                    state_next = sramx_axi_pkg::write_data;
                end
            end
            sramx_axi_pkg::read_wait: begin
                state_next = sramx_axi_pkg::read_resp; // array output settles.
            end
            sramx_axi_pkg::read_resp: begin
                if (r_ready) begin
                    state_next = sramx_axi_pkg::idle;
                end
            end
            sramx_axi_pkg::write_data: begin
                if (w_valid) begin
                    state_next = sramx_axi_pkg::write_resp;
                end
            end
            sramx_axi_pkg::write_resp: begin
                if (b_ready) begin
                    state_next = sramx_axi_pkg::idle;
                end
            end
            default: begin
                state_next = sramx_axi_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sramx_axi_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // ****************************************
    // data and response phases
    // ****************************************

    assign r_valid = (state == sramx_axi_pkg::read_resp);
    assign r_data  = rd_data; // held by the array until the next read.

    assign w_ready  = (state == sramx_axi_pkg::write_data);
    assign wr_en    = w_fire;
    assign wr_index = saved_wr_index;
    assign wr_data  = w_data;
    assign wr_strb  = w_strb;

    assign b_valid = (state == sramx_axi_pkg::write_resp);

endmodule

// File: verilog/sramx_axi_bridge.sv
module sramx_axi_bridge (
    input  logic                       clk,
    input  logic                       reset,

    // sram-style request side.
    input  logic                       sramx_req,
    input  logic                       sramx_wr,
    input  sramx_axi_pkg::sramx_size_t sramx_size,
    input  sramx_axi_pkg::addr_t       sramx_addr,
    input  sramx_axi_pkg::word_t       sramx_wdata,
    output logic                       sramx_addr_ok,
    output logic                       sramx_data_ok,
    output sramx_axi_pkg::word_t       sramx_rdata,

    // axi read address and data.
    output logic                       ar_valid,
    output sramx_axi_pkg::addr_t       ar_addr,
    input  logic                       ar_ready,
    input  logic                       r_valid,
    input  sramx_axi_pkg::word_t       r_data,
    output logic                       r_ready,

    // axi write address, data and response.
    output logic                       aw_valid,
    output sramx_axi_pkg::addr_t       aw_addr,
    input  logic                       aw_ready,
    output logic                       w_valid,
    output sramx_axi_pkg::word_t       w_data,
    output sramx_axi_pkg::strobe_t     w_strb,
    input  logic                       w_ready,
    input  logic                       b_valid,
    output logic                       b_ready
);

    // bit positions in the channel flag vectors.
    localparam int CH_AR = 4;
    localparam int CH_R  = 3;
    localparam int CH_AW = 2;
    localparam int CH_W  = 1;
    localparam int CH_B  = 0;

    logic [4:0] pending;    // channels still open from an earlier cycle.
    logic [4:0] next_issue;
    logic [4:0] issue;
    logic [4:0] handshake;
    logic [4:0] remain;
    logic       busy;

    sramx_axi_pkg::sramx_size_t saved_size;
    sramx_axi_pkg::addr_t       saved_addr;
    sramx_axi_pkg::word_t       saved_wdata;
    sramx_axi_pkg::sramx_size_t body_size;
    sramx_axi_pkg::addr_t       body_addr;
    sramx_axi_pkg::word_t       body_wdata;
    sramx_axi_pkg::strobe_t     strb;

    // ****************************************
    // channel tracking
    // ****************************************

    always_comb begin
        next_issue = 5'b00000;
        if (sramx_req) begin
            next_issue = sramx_wr ? 5'b00111 : 5'b11000;
        end
    end

    assign busy  = |pending;
    assign issue = busy ? pending : next_issue; // new request opens at once.

    assign handshake = {
        issue[CH_AR] && ar_ready,
        issue[CH_R]  && r_valid,
        issue[CH_AW] && aw_ready,
        issue[CH_W]  && w_ready,
        issue[CH_B]  && b_valid
    };
    assign remain = issue & ~handshake;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 5'b00000;
        end else begin
            pending <= remain;
        end
    end

    // request body, live when idle and held while busy.
    always_ff @(posedge clk) begin
        if (!busy) begin
            saved_size  <= sramx_size;
            saved_addr  <= sramx_addr;
            saved_wdata <= sramx_wdata;
        end
    end

    assign body_size  = busy ? saved_size  : sramx_size;
    assign body_addr  = busy ? saved_addr  : sramx_addr;
    assign body_wdata = busy ? saved_wdata : sramx_wdata;

    // ****************************************
    // byte strobes
    // ****************************************

    always_comb begin
        case ({body_size, body_addr[1:0]})
            4'b00_00: strb = 4'b0001;
            4'b00_01: strb = 4'b0010;
            4'b00_10: strb = 4'b0100;
            4'b00_11: strb = 4'b1000;
            4'b01_00: strb = 4'b0011;
            4'b01_10: strb = 4'b1100;
            4'b10_00: strb = 4'b1111;
            default:  strb = 4'b0000; // misaligned or size 3 writes nothing.
        endcase
    end

    // ****************************************
    // port drivers
    // ****************************************

    assign sramx_addr_ok = !busy;
    assign sramx_data_ok = handshake[CH_R] || handshake[CH_W];
    assign sramx_rdata   = r_data;

    assign ar_valid = issue[CH_AR];
    assign ar_addr  = body_addr;
    assign r_ready  = issue[CH_R];

    assign aw_valid = issue[CH_AW];
    assign aw_addr  = body_addr;
    assign w_valid  = issue[CH_W];
    assign w_data   = body_wdata;
    assign w_strb   = strb;
    assign b_ready  = issue[CH_B];

endmodule

// File: verilog/sramx_axi_top.sv
module sramx_axi_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sramx_req,
    input  logic                       sramx_wr,
    input  sramx_axi_pkg::sramx_size_t sramx_size,
    input  sramx_axi_pkg::addr_t       sramx_addr,
    input  sramx_axi_pkg::word_t       sramx_wdata,
    output logic                       sramx_addr_ok,
    output logic                       sramx_data_ok,
    output sramx_axi_pkg::word_t       sramx_rdata
);

    // ****************************************
    // axi channels
    // ****************************************

    logic                   ar_valid;
    logic                   ar_ready;
    sramx_axi_pkg::addr_t   ar_addr;
    logic                   r_valid;
    logic                   r_ready;
    sramx_axi_pkg::word_t   r_data;
    logic                   aw_valid;
    logic                   aw_ready;
    sramx_axi_pkg::addr_t   aw_addr;
    logic                   w_valid;
    logic                   w_ready;
    sramx_axi_pkg::word_t   w_data;
    sramx_axi_pkg::strobe_t w_strb;
    logic                   b_valid;
    logic                   b_ready;

    // array port.
    logic                       rd_en;
    sramx_axi_pkg::word_index_t rd_index;
    sramx_axi_pkg::word_t       rd_data;
    logic                       wr_en;
    sramx_axi_pkg::word_index_t wr_index;
    sramx_axi_pkg::word_t       wr_data;
    sramx_axi_pkg::strobe_t     wr_strb;

    // ****************************************
    // request conversion, sequencing, storage
    // ****************************************

    sramx_axi_bridge sramx_axi_bridge_i (
        .clk           (clk),
        .reset         (reset),
        .sramx_req     (sramx_req),
        .sramx_wr      (sramx_wr),
        .sramx_size    (sramx_size),
        .sramx_addr    (sramx_addr),
        .sramx_wdata   (sramx_wdata),
        .sramx_addr_ok (sramx_addr_ok),
        .sramx_data_ok (sramx_data_ok),
        .sramx_rdata   (sramx_rdata),
        .ar_valid      (ar_valid),
        .ar_addr       (ar_addr),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r_data        (r_data),
        .r_ready       (r_ready),
        .aw_valid      (aw_valid),
        .aw_addr       (aw_addr),
        .aw_ready      (aw_ready),
        .w_valid       (w_valid),
        .w_data        (w_data),
        .w_strb        (w_strb),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b_ready       (b_ready)
    );

    axi_sram_slave axi_sram_slave_i (
        .clk      (clk),
        .reset    (reset),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .aw_valid (aw_valid),
        .aw_addr  (aw_addr),
        .aw_ready (aw_ready),
        .w_valid  (w_valid),
        .w_data   (w_data),
        .w_strb   (w_strb),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

    sram_byte_array sram_byte_array_i (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

endmodule

// File: verification/sramx_axi_properties.sv
module sramx_axi_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   sramx_addr_ok,
    input logic                   sramx_data_ok,
    input logic                   ar_valid,
    input logic                   ar_ready,
    input sramx_axi_pkg::addr_t   ar_addr,
    input logic                   r_valid,
    input logic                   r_ready,
    input logic                   aw_valid,
    input logic                   aw_ready,
    input sramx_axi_pkg::addr_t   aw_addr,
    input logic                   w_valid,
    input logic                   w_ready,
    input sramx_axi_pkg::word_t   w_data,
    input sramx_axi_pkg::strobe_t w_strb,
    input logic                   b_valid,
    input logic                   b_ready
);

    logic waiting; // some channel stays open past this edge.

    assign waiting = (ar_valid && !ar_ready) || (r_ready && !r_valid)
                  || (aw_valid && !aw_ready) || (w_valid && !w_ready)
                  || (b_ready && !b_valid);

    // ****************************************
    // request side
    // ****************************************

    addr_ok_blocked: assert property (@(posedge clk) disable iff (reset)
        waiting |=> !sramx_addr_ok)
        else $error("addr_ok high while a channel is still open");

    data_ok_single: assert property (@(posedge clk) disable iff (reset)
        sramx_data_ok |=> !sramx_data_ok)
        else $error("data_ok lasted more than one cycle");

    // ****************************************
    // axi side
    // ****************************************

    ar_held: assert property (@(posedge clk) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_valid or ar_addr changed before ar_ready");

    aw_held: assert property (@(posedge clk) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("aw_valid or aw_addr changed before aw_ready");

    w_held: assert property (@(posedge clk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
        else $error("w_valid or write data changed before w_ready");

    one_address: assert property (@(posedge clk) disable iff (reset)
        !(ar_valid && aw_valid))
        else $error("ar_valid and aw_valid high together");

endmodule

bind sramx_axi_bridge sramx_axi_properties sramx_axi_properties_i (
    .clk           (clk),
    .reset         (reset),
    .sramx_addr_ok (sramx_addr_ok),
    .sramx_data_ok (sramx_data_ok),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .ar_addr       (ar_addr),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .aw_addr       (aw_addr),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .w_data        (w_data),
    .w_strb        (w_strb),
    .b_valid       (b_valid),
    .b_ready       (b_ready)
);

// File: verification/sramx_axi_tb.sv
`include "sramx_axi_settings.svh"

module sramx_axi_tb;

    localparam int NUM_TESTS  = 25;
    localparam int TIME_LIMIT = NUM_TESTS * 8 + 20; // in clock cycles.
    localparam int DEPTH      = 1 << `SRAMX_AXI_DEPTH_LOG2;

    logic                       clk;
    logic                       reset;
    logic                       sramx_req;
    logic                       sramx_wr;
    sramx_axi_pkg::sramx_size_t sramx_size;
    sramx_axi_pkg::addr_t       sramx_addr;
    sramx_axi_pkg::word_t       sramx_wdata;
    logic                       sramx_addr_ok;
    logic                       sramx_data_ok;
    sramx_axi_pkg::word_t       sramx_rdata;

    // ****************************************
    // stimulus table and reference model
    // ****************************************

    string                      test_name  [NUM_TESTS];
    logic                       test_wr    [NUM_TESTS];
    sramx_axi_pkg::sramx_size_t test_size  [NUM_TESTS];
    sramx_axi_pkg::addr_t       test_addr  [NUM_TESTS];
    sramx_axi_pkg::word_t       test_wdata [NUM_TESTS];
    sramx_axi_pkg::word_t       test_exp   [NUM_TESTS]; // reads only.
    int                         table_fill;

    sramx_axi_pkg::word_t model_mem [DEPTH];

    int cyc;
    int checks;
    int errors;
    int accepts;
    int data_oks;

    sramx_axi_top sramx_axi_top_i (
        .clk           (clk),
        .reset         (reset),
        .sramx_req     (sramx_req),
        .sramx_wr      (sramx_wr),
        .sramx_size    (sramx_size),
        .sramx_addr    (sramx_addr),
        .sramx_wdata   (sramx_wdata),
        .sramx_addr_ok (sramx_addr_ok),
        .sramx_data_ok (sramx_data_ok),
        .sramx_rdata   (sramx_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        int count;
        count = 0;
        while (count < TIME_LIMIT) begin
            @(posedge clk);
            count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIME_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic add_test(input string name, input logic wr,
                            input sramx_axi_pkg::sramx_size_t size,
                            input sramx_axi_pkg::addr_t addr,
                            input sramx_axi_pkg::word_t wdata,
                            input sramx_axi_pkg::word_t exp);
        test_name[table_fill]  = name;
        test_wr[table_fill]    = wr;
        test_size[table_fill]  = size;
        test_addr[table_fill]  = addr;
        test_wdata[table_fill] = wdata;
        test_exp[table_fill]   = exp;
        table_fill++;
    endtask

    task automatic build_table();
        table_fill = 0;
        add_test("word_wr_a",   1'b1, 2'd2, 32'h0000_0010, 32'h1122_3344, 32'h0);
        add_test("word_wr_b",   1'b1, 2'd2, 32'h0000_0024, 32'hA5A5_5A5A, 32'h0);
        add_test("word_wr_c",   1'b1, 2'd2, 32'h0000_03FC, 32'hDEAD_BEEF, 32'h0);
        add_test("word_rd_a",   1'b0, 2'd2, 32'h0000_0010, 32'h0,         32'h1122_3344);
        add_test("word_rd_b",   1'b0, 2'd2, 32'h0000_0024, 32'h0,         32'hA5A5_5A5A);
        add_test("word_rd_c",   1'b0, 2'd2, 32'h0000_03FC, 32'h0,         32'hDEAD_BEEF);
        // one lane per write, other lanes carry junk.
        add_test("byte_base",   1'b1, 2'd2, 32'h0000_0040, 32'h0000_0000, 32'h0);
        add_test("byte_lane0",  1'b1, 2'd0, 32'h0000_0040, 32'h1234_56AA, 32'h0);
        add_test("byte_lane1",  1'b1, 2'd0, 32'h0000_0041, 32'h1234_BB78, 32'h0);
        add_test("byte_lane2",  1'b1, 2'd0, 32'h0000_0042, 32'h55CC_6677, 32'h0);
        add_test("byte_lane3",  1'b1, 2'd0, 32'h0000_0043, 32'hDD99_8877, 32'h0);
        add_test("byte_rd",     1'b0, 2'd2, 32'h0000_0040, 32'h0,         32'hDDCC_BBAA);
        add_test("half_base",   1'b1, 2'd2, 32'h0000_0050, 32'h1234_5678, 32'h0);
        add_test("half_wr_lo",  1'b1, 2'd1, 32'h0000_0050, 32'hFFFF_ABCD, 32'h0);
        add_test("half_rd_lo",  1'b0, 2'd2, 32'h0000_0050, 32'h0,         32'h1234_ABCD);
        add_test("half_wr_hi",  1'b1, 2'd1, 32'h0000_0052, 32'h9876_FFFF, 32'h0);
        add_test("half_rd_hi",  1'b0, 2'd2, 32'h0000_0050, 32'h0,         32'h9876_ABCD);
        // misaligned and invalid sizes leave the word alone.
        add_test("bad_base",    1'b1, 2'd2, 32'h0000_0060, 32'hCAFE_F00D, 32'h0);
        add_test("bad_half",    1'b1, 2'd1, 32'h0000_0061, 32'h1111_1111, 32'h0);
        add_test("bad_word",    1'b1, 2'd2, 32'h0000_0062, 32'h2222_2222, 32'h0);
        add_test("bad_size3",   1'b1, 2'd3, 32'h0000_0060, 32'h3333_3333, 32'h0);
        add_test("bad_rd",      1'b0, 2'd2, 32'h0000_0060, 32'h0,         32'hCAFE_F00D);
        add_test("alias_wr",    1'b1, 2'd2, 32'h0000_0470, 32'h0BAD_C0DE, 32'h0);
        add_test("alias_rd_lo", 1'b0, 2'd2, 32'h0000_0070, 32'h0,         32'h0BAD_C0DE);
        add_test("alias_rd_hi", 1'b0, 2'd2, 32'h8000_0070, 32'h0,         32'h0BAD_C0DE);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // lanes touched by a request, none when misaligned.
    function automatic sramx_axi_pkg::strobe_t lane_mask(input sramx_axi_pkg::sramx_size_t size,
                                                         input logic [1:0] offset);
        sramx_axi_pkg::strobe_t mask;
        mask = 4'b0000;
        if (size == 2'd0) begin
            mask = 4'b0001 << offset;
        end else if (size == 2'd1 && !offset[0]) begin
            mask = 4'b0011 << offset;
        end else if (size == 2'd2 && offset == 2'b00) begin
            mask = 4'b1111;
        end
        return mask;
    endfunction

    function automatic sramx_axi_pkg::word_index_t model_index(input sramx_axi_pkg::addr_t addr);
        return addr[`SRAMX_AXI_DEPTH_LOG2+1:2]; // high bits alias.
    endfunction

    task automatic model_write(input sramx_axi_pkg::addr_t addr,
                               input sramx_axi_pkg::sramx_size_t size,
                               input sramx_axi_pkg::word_t data);
        sramx_axi_pkg::strobe_t mask;
        int b;
        mask = lane_mask(size, addr[1:0]);
        for (b = 0; b < 4; b++) begin
            if (mask[b]) begin
                model_mem[model_index(addr)][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic drive_entry(input int index);
        sramx_req   = 1'b1;
        sramx_wr    = test_wr[index];
        sramx_size  = test_size[index];
        sramx_addr  = test_addr[index];
        sramx_wdata = test_wdata[index];
    endtask

    task automatic report_test(input int index, input int new_errors);
        if (new_errors == 0) begin
            $display("test %0d %s: ok", index, test_name[index]);
        end else begin
            $display("test %0d %s: %0d errors", index, test_name[index], new_errors);
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin : stimulus
        int                   idx;
        int                   open_idx;
        int                   open_cyc;
        int                   open_errs;
        int                   last_accept;
        logic                 took;
        logic                 addr_ok_s;
        logic                 data_ok_s;
        sramx_axi_pkg::word_t rdata_s;
        sramx_axi_pkg::word_t model_word;

        reset       = 1'b1;
        sramx_req   = 1'b0;
        sramx_wr    = 1'b0;
        sramx_size  = 2'd0;
        sramx_addr  = '0;
        sramx_wdata = '0;
        cyc         = 0;
        checks      = 0;
        errors      = 0;
        accepts     = 0;
        data_oks    = 0;
        idx         = 0;
        open_idx    = -1;
        open_cyc    = 0;
        open_errs   = 0;
        last_accept = -1;
        build_table();
        check_value("table size", NUM_TESTS, table_fill);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        drive_entry(0); // req stays high through the whole table.

        while (data_oks < NUM_TESTS) begin
            #2; // settled, ahead of the rising edge.
            cyc++;
            addr_ok_s = sramx_addr_ok;
            data_ok_s = sramx_data_ok;
            rdata_s   = sramx_rdata;
            took      = 1'b0;
            if (cyc == 1) begin
                check_value("addr_ok after reset", 1, 32'(addr_ok_s));
                check_value("data_ok after reset", 0, 32'(data_ok_s));
            end

            if (data_ok_s) begin
                data_oks++; // every pulse, expected or not.
            end

            if (data_ok_s && open_idx < 0) begin
                errors++;
                $display("data_ok pulse at cycle %0d with no request outstanding", cyc);
            end else if (data_ok_s) begin
                check_value({test_name[open_idx], " addr_ok"}, 0, 32'(addr_ok_s));
                if (test_wr[open_idx]) begin
                    check_value({test_name[open_idx], " delay"}, 1, cyc - open_cyc);
                    model_write(test_addr[open_idx], test_size[open_idx],
                                test_wdata[open_idx]);
                end else begin
                    check_value({test_name[open_idx], " delay"}, 2, cyc - open_cyc);
                    model_word = model_mem[model_index(test_addr[open_idx])];
                    check_value({test_name[open_idx], " model"}, test_exp[open_idx], model_word);
                    check_value(test_name[open_idx], model_word, rdata_s);
                end
                report_test(open_idx, errors - open_errs);
                open_idx = -1;
            end

            if (sramx_req && addr_ok_s) begin
                took = 1'b1;
                accepts++;
                open_errs = errors;
                if (last_accept >= 0) begin
                    check_value({test_name[idx], " addr_ok gap"}, 3, cyc - last_accept);
                end
                if (open_idx >= 0) begin
                    errors++;
                    $display("%s was accepted before %s finished", test_name[idx],
                             test_name[open_idx]);
                end
                open_idx    = idx;
                open_cyc    = cyc;
                last_accept = cyc;
                idx++;
            end

            @(negedge clk);
            if (took && idx < NUM_TESTS) begin
                drive_entry(idx);
            end else if (took) begin
                sramx_req = 1'b0;
            end
        end

        // addr_ok must come back after the last transaction.
        while (cyc < last_accept + 3) begin
            #2;
            cyc++;
            if (sramx_data_ok) begin
                data_oks++;
                errors++;
                $display("extra data_ok pulse at cycle %0d", cyc);
            end
            if (cyc == last_accept + 3) begin
                check_value("addr_ok after last test", 1, 32'(sramx_addr_ok));
            end
            @(negedge clk);
        end

        check_value("accept count", NUM_TESTS, accepts);
        check_value("data_ok count", NUM_TESTS, data_oks);
        $display("summary: %0d tests, %0d checks, %0d errors", data_oks, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sramx_axi.f
+incdir+include
verilog/sramx_axi_pkg.sv
verilog/sram_byte_array.sv
verilog/axi_sram_slave.sv
verilog/sramx_axi_bridge.sv
verilog/sramx_axi_top.sv
verification/sramx_axi_properties.sv
verification/sramx_axi_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sramx_axi.f \
    --top-module sramx_axi_tb \
    -o sramx_axi_sim

output=$(./obj_dir/sramx_axi_sim)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "run_sim: pass message not found in the simulation output"
exit 1
